// ==== decodeStage.sv ====
`timescale 1ns/100ps
`default_nettype none

module decodeStage (
	input logic clk,
	input logic nrst,
	input logic stall,
	input logic squash,
	input pipePkg::fetchOutT fetchOut,
	output isaPkg::decodedT current,
	output isaPkg::decodedT decoded
);

	logic [isaPkg::instrW-1:0] word;
	logic [isaPkg::opW-1:0] opBits;
	isaPkg::decodedT decodedReg;

	// map the raw code onto the known set
	function automatic isaPkg::opcodeT opOf(input logic [isaPkg::opW-1:0] code);
		isaPkg::opcodeT op;
		case (isaPkg::opcodeT'(code))
			isaPkg::opAlu,
			isaPkg::opLoad,
			isaPkg::opStore,
			isaPkg::opBranch,
			isaPkg::opJump: op = isaPkg::opcodeT'(code);
			default: op = isaPkg::opNop; // unknown opcodes fall back to nop
		endcase
		return op;
	endfunction

	assign word = fetchOut.instr;
	assign opBits = word[isaPkg::opLsb +: isaPkg::opW];

	// unregistered decode, used by redirectUnit in the same cycle
	always_comb
	begin
		current.valid = fetchOut.valid && !squash; // wrong path words never count
		current.pc = fetchOut.pc;
		current.op = opOf(opBits);
		current.rd = word[isaPkg::rdLsb +: isaPkg::regW];
		current.rs1 = word[isaPkg::rs1Lsb +: isaPkg::regW];
		current.rs2 = word[isaPkg::rs2Lsb +: isaPkg::regW];
		if (current.op == isaPkg::opJump)
		begin
			current.imm = {{(isaPkg::instrW - isaPkg::jumpW){1'b0}},
				word[isaPkg::jumpW-1:0]};
		end
		else
		begin
			current.imm = {{(isaPkg::instrW - isaPkg::immW){word[isaPkg::immW-1]}},
				word[isaPkg::immLsb +: isaPkg::immW]};
		end
	end

	// pc field keeps the last delivered word, it doubles as the rewind point
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			decodedReg <= '0;
		end
		else if (!stall && current.valid)
		begin
			decodedReg <= current;
		end
		else
		begin
			decodedReg.valid <= 1'b0; // stalled or squashed
		end
	end

	assign decoded = decodedReg;

endmodule

`default_nettype wire

// ==== fetchStage.sv ====
`timescale 1ns/100ps
`default_nettype none

module fetchStage #(
	parameter int memWords = 256
)(
	input logic clk,
	input logic nrst,
	input logic stall,
	input pipePkg::pcSelT pcSel,
	input logic [31:0] target,
	output logic [31:0] memAddr,
	input logic [31:0] memInstr,
	output pipePkg::fetchOutT fetchOut
);

	logic [31:0] pcReg; // address being fetched
	logic [31:0] pcReg2; // address of the word leaving memory
	logic validReg;
	logic validReg2;
	logic [31:0] nextRaw;
	logic [31:0] npc;
	logic holdNow;

	// a rewind also raises stall but arrives as a target, so only pcHold freezes
	assign holdNow = stall && (pcSel == pipePkg::pcHold);

	always_comb
	begin
		case (pcSel)
			pipePkg::pcSeq:
			begin
				// the very first fetch after reset is pc 0 itself
				nextRaw = validReg ? pcReg + 32'd1 : pcReg;
			end
			pipePkg::pcZero: nextRaw = '0;
			pipePkg::pcTarget: nextRaw = target;
			default: nextRaw = pcReg;
		endcase
		npc = 32'(nextRaw % memWords); // wrap inside the memory
	end

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			pcReg <= '0;
			pcReg2 <= '0;
			validReg <= 1'b0;
			validReg2 <= 1'b0;
		end
		else if (!holdNow)
		begin
			pcReg <= npc;
			pcReg2 <= pcReg;
			validReg <= 1'b1;
			validReg2 <= validReg;
		end
	end

	// while held, re-read the word already out so memory output stays put
	assign memAddr = holdNow ? pcReg2 : pcReg;

	always_comb
	begin
		fetchOut.valid = validReg2;
		fetchOut.pc = pcReg2;
		fetchOut.instr = memInstr; // arrives one cycle after pcReg2 was addressed
	end

endmodule

`default_nettype wire

// ==== frontendTop.sv ====
`timescale 1ns/100ps
`default_nettype none

module frontendTop #(
	parameter int memWords = 256
)(
	input logic clk,
	input logic nrst,
	input logic restart,
	input logic stall,
	input pipePkg::stallKindT stallKind,
	input logic debugEn,
	input logic [31:0] debugAddr,
	input logic [31:0] debugInstr,
	output isaPkg::decodedT decoded
);

	logic [31:0] memAddr;
	logic [isaPkg::instrW-1:0] memInstr;
	pipePkg::fetchOutT fetchOut;
	pipePkg::pcSelT pcSel;
	logic [31:0] target;
	logic squash;
	isaPkg::decodedT current;

	instrMem #(
		.memWords(memWords)
	) uMem (
		.clk(clk),
		.addr(memAddr),
		.instr(memInstr),
		.debugEn(debugEn),
		.debugAddr(debugAddr),
		.debugInstr(debugInstr)
	);

	fetchStage #(
		.memWords(memWords)
	) uFetch (
		.clk(clk),
		.nrst(nrst),
		.stall(stall),
		.pcSel(pcSel),
		.target(target),
		.memAddr(memAddr),
		.memInstr(memInstr),
		.fetchOut(fetchOut)
	);

	decodeStage uDecode (
		.clk(clk),
		.nrst(nrst),
		.stall(stall),
		.squash(squash),
		.fetchOut(fetchOut),
		.current(current),
		.decoded(decoded)
	);

	redirectUnit uRedirect (
		.clk(clk),
		.nrst(nrst),
		.restart(restart),
		.stall(stall),
		.stallKind(stallKind),
		.current(current),
		.lastPc(decoded.pc), // last delivered pc, the rewind point
		.pcSel(pcSel),
		.target(target),
		.squash(squash)
	);

endmodule

`default_nettype wire

// ==== instrMem.sv ====
`timescale 1ns/100ps
`default_nettype none

module instrMem #(
	parameter int memWords = 256
)(
	input logic clk,
	input logic [31:0] addr,
	output logic [isaPkg::instrW-1:0] instr,
	input logic debugEn,
	input logic [31:0] debugAddr,
	input logic [31:0] debugInstr
);

	localparam int idxW = $clog2(memWords);

	logic [isaPkg::instrW-1:0] mem [memWords];
	logic [idxW-1:0] rdIdx;
	logic [idxW-1:0] wrIdx;

	// both ports wrap at the memory depth
	assign rdIdx = idxW'(addr % memWords);
	assign wrIdx = idxW'(debugAddr % memWords);

	always_ff @(posedge clk)
	begin
		if (debugEn)
		begin
			mem[wrIdx] <= debugInstr; // program load
		end
		instr <= mem[rdIdx]; // old data on a same address write
	end

endmodule

`default_nettype wire

// ==== isaPkg.sv ====
`default_nettype none

package isaPkg;

	localparam int instrW = 32;
	localparam int pcW = 32;
	localparam int opW = 6;
	localparam int regW = 5;
	localparam int immW = 16;
	localparam int jumpW = 26;

	// field positions inside an instruction word
	localparam int opLsb = 26;
	localparam int rdLsb = 21;
	localparam int rs1Lsb = 16;
	localparam int rs2Lsb = 11;
	localparam int immLsb = 0;

	// major opcode in bits 31:26, unknown codes decode as opNop
	typedef enum logic [opW-1:0]
	{
		opNop = 6'h00,
		opAlu = 6'h01,
		opLoad = 6'h02,
		opStore = 6'h03,
		opBranch = 6'h04, // pc relative, signed 16 bit offset
		opJump = 6'h05 // absolute word target in 25:0
	} opcodeT;

	typedef struct packed
	{
		logic valid;
		logic [pcW-1:0] pc;
		opcodeT op;
		logic [regW-1:0] rd;
		logic [regW-1:0] rs1;
		logic [regW-1:0] rs2;
		logic [instrW-1:0] imm; // sign extended, or zero extended jump field
	} decodedT;

endpackage

`default_nettype wire

// ==== pipePkg.sv ====
`default_nettype none

package pipePkg;

	// where the next fetch address comes from
	typedef enum logic [1:0]
	{
		pcSeq = 2'd0, // pc + 1
		pcZero = 2'd1, // restart
		pcTarget = 2'd2, // jump, branch or rewind target
		pcHold = 2'd3
	} pcSelT;

	// meaning of a stall request
	typedef enum logic
	{
		stallHold = 1'b0, // freeze every stage
		stallRewind = 1'b1 // refetch from the last delivered pc
	} stallKindT;

	// memory stage output handed to decode
	typedef struct packed
	{
		logic valid;
		logic [isaPkg::pcW-1:0] pc;
		logic [isaPkg::instrW-1:0] instr;
	} fetchOutT;

endpackage

`default_nettype wire

// ==== redirectUnit.sv ====
`timescale 1ns/100ps
`default_nettype none

module redirectUnit (
	input logic clk,
	input logic nrst,
	input logic restart,
	input logic stall,
	input pipePkg::stallKindT stallKind,
	input isaPkg::decodedT current,
	input logic [31:0] lastPc,
	output pipePkg::pcSelT pcSel,
	output logic [31:0] target,
	output logic squash
);

	logic hold;
	logic rewind;
	logic jumpNow;
	logic branchNow;
	logic redirect;
	logic squashReg; // marks the one younger word behind a redirect

	assign hold = stall && (stallKind == pipePkg::stallHold);
	assign rewind = stall && (stallKind == pipePkg::stallRewind);
	assign jumpNow = current.valid && (current.op == isaPkg::opJump);
	// static prediction, backward taken and forward not taken
	assign branchNow = current.valid && (current.op == isaPkg::opBranch) && current.imm[31];

	always_comb
	begin
		pcSel = pipePkg::pcSeq;
		target = '0;
		if (restart)
		begin
			pcSel = pipePkg::pcZero;
		end
		else if (rewind)
		begin
			pcSel = pipePkg::pcTarget;
			target = lastPc; // replay the last delivered word
		end
		else if (hold)
		begin
			pcSel = pipePkg::pcHold;
		end
		else if (jumpNow)
		begin
			pcSel = pipePkg::pcTarget;
			target = current.imm; // already zero extended
		end
		else if (branchNow)
		begin
			pcSel = pipePkg::pcTarget;
			target = current.pc + current.imm;
		end
	end

	assign redirect = (pcSel == pipePkg::pcZero) || (pcSel == pipePkg::pcTarget);

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
			squashReg <= 1'b0;
		else if (pcSel != pipePkg::pcHold)
			squashReg <= redirect; // held along with the pipe
	end

	// restart and rewind also drop the word now in decode
	assign squash = squashReg || restart || rewind;

endmodule

`default_nettype wire

// ==== tbClock.sv ====
`timescale 1ns/100ps
`default_nettype none

module tbClock #(
	parameter int periodNs = 40,
	parameter int resetCycles = 3
)(
	output logic clk,
	output logic nrst
);

	initial
	begin
		clk = 1'b0;
		forever #(periodNs / 2) clk = ~clk;
	end

	initial
	begin
		nrst = 1'b0;
		repeat (resetCycles) @(posedge clk);
		#2 nrst = 1'b1; // released off the edge
	end

endmodule

`default_nettype wire

// ==== tbFrontend.sv ====
`timescale 1ns/100ps
`default_nettype none

module tbFrontend;

	localparam int memWords = 256;
	localparam int progWords = 64;
	localparam int numOutputs = 300;
	localparam int cycleLimit = 10 * numOutputs;

	logic clk;
	logic nrst;
	logic restart;
	logic stall;
	pipePkg::stallKindT stallKind;
	logic debugEn;
	logic [31:0] debugAddr;
	logic [31:0] debugInstr;
	isaPkg::decodedT decodedOut;

	integer seed;
	logic [31:0] prog [progWords];
	logic [31:0] expPc; // next pc in program order
	logic [31:0] lastPc; // pc of the last valid output
	logic quietNext; // set when this cycle's event must blank the next output
	int seen = 0;
	int cycles = 0;

	tbClock #(
		.periodNs(40),
		.resetCycles(3)
	) clkGen (
		.clk(clk),
		.nrst(nrst)
	);

	frontendTop #(
		.memWords(memWords)
	) dut0 (
		.clk(clk),
		.nrst(nrst),
		.restart(restart),
		.stall(stall),
		.stallKind(stallKind),
		.debugEn(debugEn),
		.debugAddr(debugAddr),
		.debugInstr(debugInstr),
		.decoded(decodedOut)
	);

	task automatic compareValue(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("Mismatch %s: got %h, expected %h", name, got, exp);
			$display("Something failed");
			$fatal(1, "stopped at the first error");
		end
	endtask

	// opcode table of the ISA with unknown codes as nop
	function automatic isaPkg::opcodeT expectedOp(input logic [5:0] code);
		isaPkg::opcodeT op;
		case (code)
			6'h01: op = isaPkg::opAlu;
			6'h02: op = isaPkg::opLoad;
			6'h03: op = isaPkg::opStore;
			6'h04: op = isaPkg::opBranch;
			6'h05: op = isaPkg::opJump;
			default: op = isaPkg::opNop;
		endcase
		return op;
	endfunction

	function automatic logic [31:0] expectedImm(input logic [31:0] w);
		if (expectedOp(w[31:26]) == isaPkg::opJump)
			return {6'b0, w[25:0]};
		return {{16{w[15]}}, w[15:0]};
	endfunction

	// jumps and taken backward branches redirect
	function automatic logic [31:0] nextPc(input logic [31:0] pc, input logic [31:0] w);
		logic [31:0] raw;
		raw = pc + 32'd1;
		if (expectedOp(w[31:26]) == isaPkg::opJump)
			raw = {6'b0, w[25:0]};
		else if (expectedOp(w[31:26]) == isaPkg::opBranch && w[15])
			raw = pc + {{16{w[15]}}, w[15:0]};
		return 32'(raw % memWords);
	endfunction

	task automatic buildProgram();
		int i;
		int kind;
		int back;
		logic [31:0] w;
		for (i = 0; i < progWords; i++)
		begin
			w = $random(seed);
			kind = {$random(seed)} % 20;
			if (kind < 12)
			begin
				case (kind % 3)
					0: w[31:26] = isaPkg::opAlu;
					1: w[31:26] = isaPkg::opLoad;
					default: w[31:26] = isaPkg::opStore;
				endcase
			end
			else if (kind < 14)
				w[31:26] = isaPkg::opNop;
			else if (kind == 14 || kind == 19)
				w[31:26] = 6'(6 + {$random(seed)} % 58); // unused codes
			else if (kind < 18)
			begin
				w[31:26] = isaPkg::opBranch;
				if (kind == 15 && i > 0)
				begin
					back = 1 + {$random(seed)} % i; // stays at or above pc 0
					w[15:0] = -16'(back);
				end
				else
					w[15:0] = 16'(1 + {$random(seed)} % 16);
			end
			else
			begin
				w[31:26] = isaPkg::opJump;
				w[25:0] = 26'({$random(seed)} % progWords);
			end
			prog[i] = w;
		end
		// last word jumps back so fetch never runs off the program
		prog[progWords-1] = {isaPkg::opJump, 26'({$random(seed)} % 32)};
	endtask

	task automatic checkOutput();
		logic [31:0] w;
		if (quietNext)
			compareValue("decoded.valid", decodedOut.valid, 1'b0);
		if (decodedOut.valid)
		begin
			compareValue("decoded.pc", decodedOut.pc, expPc);
			w = prog[expPc % progWords];
			compareValue("decoded.op", decodedOut.op, expectedOp(w[31:26]));
			compareValue("decoded.rd", decodedOut.rd, w[25:21]);
			compareValue("decoded.rs1", decodedOut.rs1, w[20:16]);
			compareValue("decoded.rs2", decodedOut.rs2, w[15:11]);
			compareValue("decoded.imm", decodedOut.imm, expectedImm(w));
			lastPc = expPc;
			expPc = nextPc(lastPc, w);
			seen++;
		end
	endtask

	// at most one single-cycle event per cycle
	task automatic driveEvent();
		int roll;
		restart = 1'b0;
		stall = 1'b0;
		stallKind = pipePkg::stallHold;
		quietNext = 1'b0;
		roll = {$random(seed)} % 64;
		if (roll == 0)
		begin
			restart = 1'b1;
			expPc = '0;
			quietNext = 1'b1;
		end
		else if (roll < 3)
		begin
			stall = 1'b1;
			stallKind = pipePkg::stallRewind;
			expPc = lastPc; // replay the last delivered word
			quietNext = 1'b1;
		end
		else if (roll < 8)
		begin
			stall = 1'b1;
			quietNext = 1'b1;
		end
	endtask

	always @(posedge clk)
	begin
		cycles++;
		if (cycles > cycleLimit)
		begin
			$display("Timeout: only %0d of %0d outputs after %0d cycles", seen, numOutputs,
				cycles);
			$display("Something failed");
			$fatal(1, "run ended by the cycle limit");
		end
	end

	initial
	begin
		seed = 7;
		restart = 1'b1; // pipe stays parked while the program loads
		stall = 1'b0;
		stallKind = pipePkg::stallHold;
		debugEn = 1'b0;
		debugAddr = '0;
		debugInstr = '0;
		expPc = '0;
		lastPc = '0;
		quietNext = 1'b1;
		buildProgram();
		@(posedge nrst);
		for (int i = 0; i < progWords; i++)
		begin
			@(posedge clk);
			#2;
			debugEn = 1'b1;
			debugAddr = 32'(i);
			debugInstr = prog[i];
		end
		@(posedge clk);
		#2;
		debugEn = 1'b0;
		while (seen < numOutputs)
		begin
			@(posedge clk);
			#2;
			checkOutput();
			driveEvent();
		end
		$display("Everything OK");
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
isaPkg.sv
pipePkg.sv
instrMem.sv
fetchStage.sv
decodeStage.sv
redirectUnit.sv
frontendTop.sv
tbClock.sv
tbFrontend.sv
